/* Bender.yml */
package:
  name: cache

sources:
  # design, package first
  - rtl/cache_pkg.sv
  - rtl/cache_front_end.sv
  - rtl/cache_memory.sv
  - rtl/write_through_buffer.sv
  - rtl/cache_back_end.sv
  - rtl/cache_control.sv
  - rtl/cache_top.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_main_memory.sv
      - sim/tb_cache_top.sv

/* build.f */
rtl/cache_pkg.sv
rtl/cache_front_end.sv
rtl/cache_memory.sv
rtl/write_through_buffer.sv
rtl/cache_back_end.sv
rtl/cache_control.sv
rtl/cache_top.sv
sim/tb_main_memory.sv
sim/tb_cache_top.sv

/* rtl/cache_back_end.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_back_end (
   input  logic                             clk,
   input  logic                             rst_n,
   // write-through buffer
   input  cache_pkg::wtb_entry_t            head,
   input  logic                             empty,
   output logic                             pop,
   // line refill
   input  logic                             refill_valid,
   input  logic [cache_pkg::LADDR_W-1:0]    refill_line_addr,
   output logic                             refill_word_valid,
   output logic [cache_pkg::WORD_OFF_W-1:0] refill_word_idx,
   output logic [cache_pkg::DATA_W-1:0]     refill_word,
   output logic                             refill_done,
   // native memory
   output logic                             mem_valid,
   output cache_pkg::mem_req_t              mem_req,
   input  logic [cache_pkg::DATA_W-1:0]     mem_rdata,
   input  logic                             mem_ready
);

   logic [cache_pkg::WORD_OFF_W-1:0] word_cnt;
   logic                             start_wr;
   logic                             start_rd;

   // mem_valid plus we is the whole FSM, idle / write / read
   assign start_wr = !mem_valid && !empty;                 // writes first
   assign start_rd = !mem_valid && empty && refill_valid && !refill_done;

   assign pop               = mem_valid & mem_req.we & mem_ready;
   assign refill_word_valid = mem_valid & ~mem_req.we & mem_ready;
   assign refill_word_idx   = word_cnt;
   assign refill_word       = mem_rdata;

   always_ff @(posedge clk)
      if (!rst_n)
      begin
         mem_valid   <= 1'b0;
         word_cnt    <= '0;
         refill_done <= 1'b0;
      end
      else
      begin
         if (start_wr || start_rd)
            mem_valid <= 1'b1;
         else if (mem_ready)
            mem_valid <= 1'b0;             // back to idle after each beat
         refill_done <= refill_word_valid && (&word_cnt);
         if (refill_word_valid)
            word_cnt <= word_cnt + 1'b1;   // wraps to 0 after the last word
      end

   // request payload
   always_ff @(posedge clk)
      if (start_wr)
         mem_req <= '{addr: head.addr, wdata: head.wdata, wstrb: head.wstrb, we: 1'b1};
      else if (start_rd)
         mem_req <= '{addr: {refill_line_addr, word_cnt}, wdata: '0, wstrb: '0, we: 1'b0};

   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

   // memory ordering, no refill read ahead of a pending write
   a_read_drained: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_req.we |-> empty);

endmodule

`default_nettype wire

/* rtl/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_control (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              ctrl_valid,
   input  logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
   output logic [cache_pkg::DATA_W-1:0]      ctrl_rdata,
   output logic                              ctrl_ready,
   input  cache_pkg::cache_event_t           events,
   input  logic                              wtb_empty,
   output logic                              invalidate
);

   logic [cache_pkg::DATA_W-1:0] cnt [$bits(cache_pkg::cache_event_t)];
   logic [$bits(cache_pkg::cache_event_t)-1:0] ev;
   logic accept;

   assign ev     = events;                   // bit n is counter n
   assign accept = ctrl_valid & ~ctrl_ready;

   ////////////////////////////////////////
   // hit and miss counters
   ////////////////////////////////////////
   always_ff @(posedge clk)
      if (!rst_n || (accept && ctrl_addr == cache_pkg::CTRL_CLEAR_CNT))
         for (int i = 0; i < $bits(ev); i++)
            cnt[i] <= '0;
      else
         for (int i = 0; i < $bits(ev); i++)
            if (ev[i] && !(&cnt[i]))
               cnt[i] <= cnt[i] + 1'b1;      // saturates at all ones

   always_ff @(posedge clk)
      if (!rst_n)
      begin
         ctrl_ready <= 1'b0;
         invalidate <= 1'b0;
      end
      else
      begin
         ctrl_ready <= accept;               // one cycle pulse
         invalidate <= accept && ctrl_addr == cache_pkg::CTRL_INVALIDATE;
      end

   // readback
   always_ff @(posedge clk)
      if (accept)
         case (ctrl_addr)
            cache_pkg::CTRL_READ_HIT, cache_pkg::CTRL_READ_MISS,
            cache_pkg::CTRL_WRITE_HIT, cache_pkg::CTRL_WRITE_MISS:
               ctrl_rdata <= cnt[ctrl_addr[1:0]];
            cache_pkg::CTRL_WTB_EMPTY:
               ctrl_rdata <= {{(cache_pkg::DATA_W-1){1'b0}}, wtb_empty};
            default:
               ctrl_rdata <= '0;             // command codes read zero
         endcase

endmodule

`default_nettype wire

/* rtl/cache_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_front_end (
   input  logic                              clk,
   input  logic                              rst_n,
   // requester
   input  logic                              valid,
   input  logic [cache_pkg::ADDR_W:0]        addr,       // msb selects controller
   input  cache_pkg::cache_req_t             req,
   output logic [cache_pkg::DATA_W-1:0]      rdata,
   output logic                              ready,
   // cache memory
   output logic                              data_valid,
   input  logic [cache_pkg::DATA_W-1:0]      data_rdata,
   input  logic                              data_ready,
   output cache_pkg::cache_req_t             req_reg,
   // controller
   output logic                              ctrl_valid,
   output logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
   input  logic [cache_pkg::DATA_W-1:0]      ctrl_rdata,
   input  logic                              ctrl_ready
);

   logic busy;      // an access is in flight
   logic ctrl_sel;

   assign busy     = data_valid | ctrl_valid;
   assign ctrl_sel = addr[cache_pkg::ADDR_W];

   // latch on the first cycle valid is seen while idle
   always_ff @(posedge clk)
      if (valid && !busy)
      begin
         req_reg.addr  <= addr[cache_pkg::ADDR_W-1:cache_pkg::BYTE_W];
         req_reg.wdata <= req.wdata;
         req_reg.wstrb <= req.wstrb;
         ctrl_addr     <= addr[cache_pkg::BYTE_W +: cache_pkg::CTRL_ADDR_W];
      end

   always_ff @(posedge clk)
      if (!rst_n)
      begin
         data_valid <= 1'b0;
         ctrl_valid <= 1'b0;
      end
      else if (!busy)
      begin
         data_valid <= valid & ~ctrl_sel;
         ctrl_valid <= valid & ctrl_sel;
      end
      else
      begin
         data_valid <= data_valid & ~data_ready;  // held until answered
         ctrl_valid <= ctrl_valid & ~ctrl_ready;
      end

   // only one side answers per access
   assign ready = data_ready | ctrl_ready;
   assign rdata = ctrl_valid ? ctrl_rdata : data_rdata;

endmodule

`default_nettype wire

/* rtl/cache_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_memory (
   input  logic                                clk,
   input  logic                                rst_n,
   // front end
   input  logic                                data_valid,
   input  cache_pkg::cache_req_t               req_reg,
   output logic [cache_pkg::DATA_W-1:0]        data_rdata,
   output logic                                data_ready,
   // write-through buffer
   input  logic                                wtb_full,
   input  logic                                wtb_empty,
   output logic                                push,
   output cache_pkg::wtb_entry_t               push_entry,
   // refill from back end
   output logic                                refill_valid,
   output logic [cache_pkg::LADDR_W-1:0]       refill_line_addr,
   input  logic                                refill_word_valid,
   input  logic [cache_pkg::WORD_OFF_W-1:0]    refill_word_idx,
   input  logic [cache_pkg::DATA_W-1:0]        refill_word,
   input  logic                                refill_done,
   // controller
   input  logic                                invalidate,
   output cache_pkg::cache_event_t             events
);

   logic [cache_pkg::TAG_W-1:0]  tag_mem  [2**cache_pkg::LINE_OFF_W];
   logic [cache_pkg::DATA_W-1:0] data_mem [2**(cache_pkg::LINE_OFF_W+cache_pkg::WORD_OFF_W)];
   logic [2**cache_pkg::LINE_OFF_W-1:0] valid_bits;

   logic [cache_pkg::TAG_W-1:0]                            tag;
   logic [cache_pkg::LINE_OFF_W+cache_pkg::WORD_OFF_W-1:0] idx;   // line and word
   logic [cache_pkg::LINE_OFF_W-1:0]                       line;
   logic hit;
   logic is_write;
   logic accept;
   logic wr_go;
   logic rd_hit_go;
   logic rd_miss_go;
   logic missed;    // current read already refilled once

   ////////////////////////////////////////
   // lookup
   ////////////////////////////////////////
   assign {tag, idx} = req_reg.addr;
   assign line       = idx[cache_pkg::LINE_OFF_W+cache_pkg::WORD_OFF_W-1:cache_pkg::WORD_OFF_W];
   assign hit        = valid_bits[line] && (tag_mem[line] == tag);
   assign is_write   = |req_reg.wstrb;

   // data_ready guards the answer cycle, data_valid is still high then
   assign accept     = data_valid & ~data_ready & ~refill_valid;
   assign wr_go      = accept & is_write & ~wtb_full;           // stalls while full
   assign rd_hit_go  = accept & ~is_write & hit;
   assign rd_miss_go = accept & ~is_write & ~hit & wtb_empty;   // drain first

   assign refill_line_addr = {tag, line};
   assign push_entry       = '{addr: req_reg.addr, wdata: req_reg.wdata, wstrb: req_reg.wstrb};

   ////////////////////////////////////////
   // control state
   ////////////////////////////////////////
   always_ff @(posedge clk)
      if (!rst_n)
      begin
         data_ready   <= 1'b0;
         push         <= 1'b0;
         refill_valid <= 1'b0;
         missed       <= 1'b0;
         events       <= '0;
         valid_bits   <= '0;
      end
      else
      begin
         data_ready        <= wr_go | rd_hit_go;
         push              <= wr_go;                 // lands with ready
         events.write_hit  <= wr_go & hit;
         events.write_miss <= wr_go & ~hit;          // no allocate
         events.read_hit   <= rd_hit_go & ~missed;
         events.read_miss  <= rd_hit_go & missed;
         if (rd_hit_go)
            missed <= 1'b0;
         if (rd_miss_go)
         begin
            refill_valid <= 1'b1;
            missed       <= 1'b1;
         end
         if (refill_done)
         begin
            refill_valid     <= 1'b0;
            valid_bits[line] <= 1'b1;  // answered from the line next cycle
         end
         if (invalidate)
            valid_bits <= '0;
      end

   ////////////////////////////////////////
   // arrays
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (refill_word_valid)
         data_mem[{line, refill_word_idx}] <= refill_word;
      if (wr_go && hit)
         for (int b = 0; b < cache_pkg::NBYTES; b++)
            if (req_reg.wstrb[b])
               data_mem[idx][8*b +: 8] <= req_reg.wdata[8*b +: 8];  // byte merge
      if (rd_hit_go)
         data_rdata <= data_mem[idx];
      if (refill_done)
         tag_mem[line] <= tag;
   end

   // full was checked a cycle earlier, nothing else pushes
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> !wtb_full);

   // refill only behind a drained buffer
   a_refill_empty: assert property (@(posedge clk) disable iff (!rst_n)
      refill_valid |-> wtb_empty);

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   ////////////////////////////////////////
   // geometry
   ////////////////////////////////////////
   localparam int ADDR_W      = 16;          // byte address, select bit not included
   localparam int DATA_W      = 32;
   localparam int NBYTES      = DATA_W / 8;  // also the strobe width
   localparam int BYTE_W      = 2;
   localparam int WORD_OFF_W  = 2;           // 4 words per line
   localparam int LINE_OFF_W  = 4;           // 16 lines
   localparam int TAG_W       = ADDR_W - LINE_OFF_W - WORD_OFF_W - BYTE_W;
   localparam int WTB_DEPTH_W = 2;           // 4 pending writes

   localparam int WADDR_W = ADDR_W - BYTE_W;    // word address
   localparam int LADDR_W = TAG_W + LINE_OFF_W; // line address

   ////////////////////////////////////////
   // controller codes, word address under the select bit
   ////////////////////////////////////////
   localparam int CTRL_ADDR_W = 3;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_READ_HIT   = 3'd0;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_READ_MISS  = 3'd1;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_WRITE_HIT  = 3'd2;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_WRITE_MISS = 3'd3;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_WTB_EMPTY  = 3'd4;  // flag in bit 0
   localparam logic [CTRL_ADDR_W-1:0] CTRL_INVALIDATE = 3'd5;
   localparam logic [CTRL_ADDR_W-1:0] CTRL_CLEAR_CNT  = 3'd6;

   typedef struct packed {
      logic [WADDR_W-1:0] addr;
      logic [DATA_W-1:0]  wdata;
      logic [NBYTES-1:0]  wstrb;  // zero strobe is a read
   } cache_req_t;

   // native port, held until mem_ready
   typedef struct packed {
      logic [WADDR_W-1:0] addr;
      logic [DATA_W-1:0]  wdata;
      logic [NBYTES-1:0]  wstrb;
      logic               we;
   } mem_req_t;

   typedef struct packed {
      logic [WADDR_W-1:0] addr;
      logic [DATA_W-1:0]  wdata;
      logic [NBYTES-1:0]  wstrb;
   } wtb_entry_t;

   // bit n pairs with counter code n
   typedef struct packed {
      logic write_miss;
      logic write_hit;
      logic read_miss;
      logic read_hit;
   } cache_event_t;

endpackage

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
   input  logic                         clk,
   input  logic                         rst_n,
   // requester
   input  logic                         valid,
   input  logic [cache_pkg::ADDR_W:0]   addr,        // msb selects controller
   input  cache_pkg::cache_req_t        req,
   output logic [cache_pkg::DATA_W-1:0] rdata,
   output logic                         ready,
   // native memory
   output logic                         mem_valid,
   output cache_pkg::mem_req_t          mem_req,
   input  logic [cache_pkg::DATA_W-1:0] mem_rdata,
   input  logic                         mem_ready
);

   ////////////////////////////////////////
   // front end to memory and controller
   ////////////////////////////////////////
   logic                              data_valid;
   logic                              data_ready;
   logic [cache_pkg::DATA_W-1:0]      data_rdata;
   cache_pkg::cache_req_t             req_reg;
   logic                              ctrl_valid;
   logic                              ctrl_ready;
   logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr;
   logic [cache_pkg::DATA_W-1:0]      ctrl_rdata;
   cache_pkg::cache_event_t           events;
   logic                              invalidate;

   // write channel
   logic                              push;
   cache_pkg::wtb_entry_t             push_entry;
   logic                              pop;
   cache_pkg::wtb_entry_t             head;
   logic                              wtb_full;
   logic                              wtb_empty;

   // refill channel
   logic                              refill_valid;
   logic [cache_pkg::LADDR_W-1:0]     refill_line_addr;
   logic                              refill_word_valid;
   logic [cache_pkg::WORD_OFF_W-1:0]  refill_word_idx;
   logic [cache_pkg::DATA_W-1:0]      refill_word;
   logic                              refill_done;

   cache_front_end u_front_end (.*);

   cache_memory u_cache_memory (.*);

   write_through_buffer u_wtb (
      .full  (wtb_full),
      .empty (wtb_empty),
      .*
   );

   cache_back_end u_back_end (
      .empty (wtb_empty),
      .*
   );

   cache_control u_cache_control (.*);

endmodule

`default_nettype wire

/* rtl/write_through_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_through_buffer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  cache_pkg::wtb_entry_t push_entry,
   input  logic                  pop,
   output cache_pkg::wtb_entry_t head,
   output logic                  full,
   output logic                  empty
);

   cache_pkg::wtb_entry_t             fifo_mem [2**cache_pkg::WTB_DEPTH_W];
   logic [cache_pkg::WTB_DEPTH_W-1:0] rd_ptr;
   logic [cache_pkg::WTB_DEPTH_W-1:0] wr_ptr;
   logic [cache_pkg::WTB_DEPTH_W:0]   count;

   assign head  = fifo_mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = count[cache_pkg::WTB_DEPTH_W];  // msb only set at depth

   always_ff @(posedge clk)
      if (push)
         fifo_mem[wr_ptr] <= push_entry;

   always_ff @(posedge clk)
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;    // wraps
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // both or neither
         endcase
      end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> !empty);

   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push && full |-> pop);

endmodule

`default_nettype wire

/* sim/tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

   localparam int N_ACCESS   = 320;                  // bound over all five tests
   localparam int MAX_CYCLES = 40 * N_ACCESS + 200;
   localparam int N_LINES    = 2**cache_pkg::LINE_OFF_W;
   localparam logic [1:0] KIND_NONE  = 2'd0;         // writes and commands
   localparam logic [1:0] KIND_WORD  = 2'd1;
   localparam logic [1:0] KIND_COUNT = 2'd2;

   // what the next ready should bring
   typedef struct packed {
      logic [1:0]                        kind;
      logic [cache_pkg::CTRL_ADDR_W-1:0] code;
      logic [cache_pkg::DATA_W-1:0]      value;
   } expect_t;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          valid;
   logic [cache_pkg::ADDR_W:0]    addr;
   cache_pkg::cache_req_t         req;
   logic [cache_pkg::DATA_W-1:0]  rdata;
   logic                          ready;
   logic                          mem_valid;
   cache_pkg::mem_req_t           mem_req;
   logic [cache_pkg::DATA_W-1:0]  mem_rdata;
   logic                          mem_ready;
   logic [cache_pkg::WADDR_W-1:0] peek_addr;
   logic [cache_pkg::DATA_W-1:0]  peek_data;

   ////////////////////////////////////////
   // reference model state
   ////////////////////////////////////////
   logic [7:0]                   shadow [2**cache_pkg::ADDR_W];
   logic [cache_pkg::TAG_W-1:0]  sh_tag [N_LINES];
   logic                         sh_valid [N_LINES];
   logic [cache_pkg::DATA_W-1:0] exp_cnt [2**cache_pkg::CTRL_ADDR_W];  // codes 0..3 used
   expect_t                      exp_q [$];
   expect_t                      cur_exp;
   logic [31:0]                  rng_state = 32'h6d54;
   int                           err_count = 0;
   int                           n_checks = 0;
   int                           test_err_base = 0;
   int                           cycles = 0;

   always #5 clk = ~clk;  // 10 ns

   cache_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .addr      (addr),
      .req       (req),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   tb_main_memory u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready),
      .peek_addr (peek_addr),
      .peek_data (peek_data)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // two tags on four lines so lines get evicted
   function automatic logic [cache_pkg::WADDR_W-1:0] pool_addr(input logic [4:0] r);
      return {7'h10, r[0], 2'b00, r[2:1], r[4:3]};  // tag, line, word
   endfunction

   function automatic logic [cache_pkg::DATA_W-1:0] expect_read(
      input logic [cache_pkg::WADDR_W-1:0] waddr);
      logic [cache_pkg::DATA_W-1:0] w;
      for (int b = 0; b < cache_pkg::NBYTES; b++)
         w[8*b +: 8] = shadow[waddr * cache_pkg::NBYTES + b];  // strobe bit b is byte b
      return w;
   endfunction

   // direct mapped, reads allocate, writes never do
   function automatic logic predict_hit(input logic [cache_pkg::WADDR_W-1:0] waddr);
      logic [cache_pkg::LINE_OFF_W-1:0] line;
      line = waddr[cache_pkg::WORD_OFF_W +: cache_pkg::LINE_OFF_W];
      return sh_valid[line] && (sh_tag[line] == waddr[cache_pkg::WADDR_W-1 -: cache_pkg::TAG_W]);
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic check_word(input string name, input logic [cache_pkg::DATA_W-1:0] got,
                             input logic [cache_pkg::DATA_W-1:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_count(input logic [cache_pkg::CTRL_ADDR_W-1:0] code,
                              input logic [cache_pkg::DATA_W-1:0] got,
                              input logic [cache_pkg::DATA_W-1:0] exp);
      string name;
      case (code)
         cache_pkg::CTRL_READ_HIT:  name = "read_hit counter";
         cache_pkg::CTRL_READ_MISS: name = "read_miss counter";
         cache_pkg::CTRL_WRITE_HIT: name = "write_hit counter";
         default:                   name = "write_miss counter";
      endcase
      n_checks++;
      if (got !== exp)
      begin
         err_count++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      err_count++;
      $display("%s", msg);
   endtask

   // comparator samples rdata mid cycle where it is stable
   always @(negedge clk)
      if (rst_n && ready)
      begin
         if (exp_q.size() == 0)
            report_error("ready pulsed with no access outstanding");
         else
         begin
            cur_exp = exp_q.pop_front();
            if (cur_exp.kind == KIND_WORD)
               check_word("rdata", rdata, cur_exp.value);
            else if (cur_exp.kind == KIND_COUNT)
               check_count(cur_exp.code, rdata, cur_exp.value);
         end
      end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout after %0d cycles, the cache stopped answering", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // access tasks entered 1 ns after a rising edge
   ////////////////////////////////////////
   task automatic run_access(input logic ctrl, input logic [cache_pkg::ADDR_W-1:0] baddr,
                             input logic [cache_pkg::DATA_W-1:0] wdata,
                             input logic [cache_pkg::NBYTES-1:0] wstrb,
                             input expect_t e, output logic [cache_pkg::DATA_W-1:0] rd);
      exp_q.push_back(e);
      valid     = 1'b1;
      addr      = {ctrl, baddr};
      req.addr  = baddr[cache_pkg::ADDR_W-1:cache_pkg::BYTE_W];
      req.wdata = wdata;
      req.wstrb = wstrb;
      do
         @(negedge clk);
      while (!ready);
      rd = rdata;
      @(posedge clk);
      #1;
      valid = 1'b0;  // a following access takes over in the same step
   endtask

   task automatic data_read(input logic [cache_pkg::WADDR_W-1:0] waddr);
      logic [cache_pkg::LINE_OFF_W-1:0] line;
      logic [cache_pkg::DATA_W-1:0]     rd;
      expect_t                          e;
      line = waddr[cache_pkg::WORD_OFF_W +: cache_pkg::LINE_OFF_W];
      e    = '{kind: KIND_WORD, code: '0, value: expect_read(waddr)};
      if (predict_hit(waddr))
         exp_cnt[cache_pkg::CTRL_READ_HIT] = exp_cnt[cache_pkg::CTRL_READ_HIT] + 1;
      else
      begin
         exp_cnt[cache_pkg::CTRL_READ_MISS] = exp_cnt[cache_pkg::CTRL_READ_MISS] + 1;
         sh_valid[line] = 1'b1;  // refill
         sh_tag[line]   = waddr[cache_pkg::WADDR_W-1 -: cache_pkg::TAG_W];
      end
      run_access(1'b0, {waddr, {cache_pkg::BYTE_W{1'b0}}}, '0, '0, e, rd);
   endtask

   task automatic data_write(input logic [cache_pkg::WADDR_W-1:0] waddr,
                             input logic [cache_pkg::DATA_W-1:0] wdata,
                             input logic [cache_pkg::NBYTES-1:0] wstrb);
      logic [cache_pkg::DATA_W-1:0] rd;
      if (predict_hit(waddr))
         exp_cnt[cache_pkg::CTRL_WRITE_HIT] = exp_cnt[cache_pkg::CTRL_WRITE_HIT] + 1;
      else
         exp_cnt[cache_pkg::CTRL_WRITE_MISS] = exp_cnt[cache_pkg::CTRL_WRITE_MISS] + 1;
      for (int b = 0; b < cache_pkg::NBYTES; b++)
         if (wstrb[b])
            shadow[waddr * cache_pkg::NBYTES + b] = wdata[8*b +: 8];
      run_access(1'b0, {waddr, {cache_pkg::BYTE_W{1'b0}}}, wdata, wstrb,
                 '{kind: KIND_NONE, code: '0, value: '0}, rd);
   endtask

   task automatic ctrl_access(input logic [cache_pkg::CTRL_ADDR_W-1:0] sel_code,
                              output logic [cache_pkg::DATA_W-1:0] rd);
      expect_t e;
      e = '{kind: KIND_NONE, code: sel_code, value: '0};
      if (sel_code <= cache_pkg::CTRL_WRITE_MISS)
         e = '{kind: KIND_COUNT, code: sel_code, value: exp_cnt[sel_code]};
      run_access(1'b1, {{(cache_pkg::ADDR_W-cache_pkg::CTRL_ADDR_W-cache_pkg::BYTE_W){1'b0}},
                        sel_code, {cache_pkg::BYTE_W{1'b0}}}, '0, '0, e, rd);
      if (sel_code == cache_pkg::CTRL_INVALIDATE)
         for (int l = 0; l < N_LINES; l++)
            sh_valid[l] = 1'b0;
      if (sel_code == cache_pkg::CTRL_CLEAR_CNT)
         for (int i = 0; i < 2**cache_pkg::CTRL_ADDR_W; i++)
            exp_cnt[i] = '0;
   endtask

   task automatic read_counters();
      logic [cache_pkg::DATA_W-1:0] rd;
      for (int c = 0; c < 4; c++)
         ctrl_access(c[cache_pkg::CTRL_ADDR_W-1:0], rd);
   endtask

   task automatic random_access();
      logic [31:0]                 r;
      logic [cache_pkg::NBYTES-1:0] strb;
      rng_state = xorshift(rng_state);
      r         = rng_state;
      strb      = r[8:5];
      if (r[9] && strb != '0)
      begin
         rng_state = xorshift(rng_state);
         data_write(pool_addr(r[4:0]), rng_state, strb);  // partial strobes too
      end
      else
         data_read(pool_addr(r[4:0]));
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial
   begin : stimulus
      logic [cache_pkg::DATA_W-1:0]  rd;
      logic [cache_pkg::WADDR_W-1:0] reread_q [$];
      logic [cache_pkg::WADDR_W-1:0] hit_addr;
      int                            polls;
      rst_n     = 1'b0;
      valid     = 1'b0;
      addr      = '0;
      req       = '0;
      peek_addr = '0;
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++)
         shadow[i] = 8'(i) ^ 8'(i >> 8);  // backing memory fill
      for (int l = 0; l < N_LINES; l++)
      begin
         sh_valid[l] = 1'b0;
         sh_tag[l]   = '0;
      end
      for (int i = 0; i < 2**cache_pkg::CTRL_ADDR_W; i++)
         exp_cnt[i] = '0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      repeat (200) random_access();
      end_test(1, "write then read");

      repeat (60) random_access();
      read_counters();  // counts since reset
      end_test(2, "hit and miss counters");

      polls = 0;
      do
      begin
         ctrl_access(cache_pkg::CTRL_WTB_EMPTY, rd);
         polls++;
      end
      while (rd[0] !== 1'b1 && polls < 20);
      if (rd[0] !== 1'b1)
         report_error("write buffer still not empty after 20 polls");
      for (int i = 0; i < 32; i++)  // whole address pool
      begin
         peek_addr = pool_addr(i[4:0]);
         #1;
         check_word("peek_data", peek_data, expect_read(peek_addr));
      end
      @(posedge clk);
      #1;
      end_test(3, "write-through to memory");

      for (int l = 0; l < N_LINES; l++)
         if (sh_valid[l])
            reread_q.push_back({sh_tag[l], l[cache_pkg::LINE_OFF_W-1:0],
                                l[cache_pkg::WORD_OFF_W-1:0]});
      if (reread_q.size() == 0)
         report_error("no line was cached before the invalidate");
      ctrl_access(cache_pkg::CTRL_INVALIDATE, rd);
      foreach (reread_q[i])
         data_read(reread_q[i]);  // each one a miss now
      read_counters();
      end_test(4, "invalidate");

      hit_addr = (reread_q.size() != 0) ? reread_q[0] : pool_addr(5'd0);
      data_read(hit_addr);        // line surely cached
      ctrl_access(cache_pkg::CTRL_CLEAR_CNT, rd);
      read_counters();
      data_read(hit_addr);
      read_counters();            // read_hit alone at 1
      end_test(5, "clear counters");

      $display("5 tests, %0d checks, %0d errors", n_checks, err_count);
      if (err_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/tb_main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_main_memory (
   input  logic                          clk,
   input  logic                          rst_n,
   // native port
   input  logic                          mem_valid,
   input  cache_pkg::mem_req_t           mem_req,
   output logic [cache_pkg::DATA_W-1:0]  mem_rdata,
   output logic                          mem_ready,
   // backdoor read for the testbench
   input  logic [cache_pkg::WADDR_W-1:0] peek_addr,
   output logic [cache_pkg::DATA_W-1:0]  peek_data
);

   logic [7:0] mem [2**cache_pkg::ADDR_W];  // 64 Ki bytes
   logic       wait_done;                   // first latency cycle spent

   initial
   begin
      mem_rdata = '0;
      mem_ready = 1'b0;
      wait_done = 1'b0;
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++)
         mem[i] = 8'(i) ^ 8'(i >> 8);       // every address bit shows up
   end

   // ready two cycles after valid, for one cycle
   always @(posedge clk)
      if (!rst_n)
      begin
         mem_ready <= 1'b0;
         wait_done <= 1'b0;
      end
      else if (mem_valid && !mem_ready)
      begin
         wait_done <= ~wait_done;
         mem_ready <= wait_done;
         if (wait_done)
            for (int b = 0; b < cache_pkg::NBYTES; b++)
            begin
               if (mem_req.we && mem_req.wstrb[b])
                  mem[mem_req.addr * cache_pkg::NBYTES + b] <= mem_req.wdata[8*b +: 8];
               mem_rdata[8*b +: 8] <= mem[mem_req.addr * cache_pkg::NBYTES + b];
            end
      end
      else
         mem_ready <= 1'b0;

   always_comb
      for (int b = 0; b < cache_pkg::NBYTES; b++)
         peek_data[8*b +: 8] = mem[peek_addr * cache_pkg::NBYTES + b];

endmodule

`default_nettype wire
